// ==== Makefile ====
# Verilator flow for the TLK2711 link controller

VERILATOR ?= verilator
TOP       ?= tb_tlk_link
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
PASS_TEXT ?= ALL TESTS PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== flist.f ====
+incdir+testbench
hw/tlk_link_pkg.sv
hw/tlk_link_regs.sv
hw/tlk_tx_framer.sv
hw/tlk_rx_deframer.sv
hw/tlk_link_top.sv
testbench/tb_tlk_link.sv

// ==== hw/tlk_link_pkg.sv ====
// TLK2711 link controller definitions
package tlk_link_pkg;

    //////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////

    localparam int WORD_W = 16;
    localparam int REG_AW = 8;
    localparam int REG_DW = 32;
    localparam int LEN_W  = 12;

    // Control words, sent with both K flags set
    localparam logic [WORD_W-1:0] K_SOF  = 16'hFBFB;
    localparam logic [WORD_W-1:0] K_EOF  = 16'hFDFD;
    localparam logic [WORD_W-1:0] K_IDLE = 16'hBCBC;

    //////////////////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////////////////

    typedef enum logic [REG_AW-1:0] {
        REG_CTRL      = 8'h00,
        REG_TX_LEN    = 8'h04,
        REG_STATUS    = 8'h08,
        REG_RX_FRAMES = 8'h0C,
        REG_RX_ERRORS = 8'h10,
        REG_IRQ_STAT  = 8'h14,
        REG_IRQ_MASK  = 8'h18
    } reg_addr_e;

    //////////////////////////////////////////////////////////////
    // Engine states
    //////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_SOF,
        TX_LEN,
        TX_BODY,
        TX_CSUM,
        TX_EOF
    } tx_state_e;

    typedef enum logic [2:0] {
        RX_HUNT,
        RX_LEN,
        RX_BODY,
        RX_CSUM,
        RX_EOF
    } rx_state_e;

endpackage

// ==== hw/tlk_link_regs.sv ====
// Link controller register block
`timescale 1ns/1ps

module tlk_link_regs
    import tlk_link_pkg::*;
(
    input  logic              clk,
    input  logic              i_reset,

    input  logic              i_reg_wen,
    input  logic [REG_AW-1:0] i_reg_waddr,
    input  logic [REG_DW-1:0] i_reg_wdata,
    input  logic              i_reg_ren,
    input  logic [REG_AW-1:0] i_reg_raddr,
    output logic [REG_DW-1:0] o_reg_rdata,

    input  logic              i_tx_done,
    input  logic              i_tx_busy,
    input  logic              i_rx_frame_ok,
    input  logic              i_rx_frame_bad,
    input  logic              i_rx_overflow,
    input  logic              i_rx_in_frame,

    output logic              o_tx_go,
    output logic [LEN_W-1:0]  o_tx_len,
    output logic              o_2711_enable,
    output logic              o_2711_loopen,
    output logic              o_2711_pre,
    output logic              o_tx_irq,
    output logic              o_rx_irq
);

    logic              sticky_csum;
    logic              sticky_ovf;
    logic [REG_DW-1:0] rx_frames;
    logic [REG_DW-1:0] rx_errors;
    logic [1:0]        irq_stat;
    logic [1:0]        irq_mask;
    logic [1:0]        irq_clr;
    logic              rx_done;

    // W1C strobe for the interrupt status
    assign irq_clr = (i_reg_wen && i_reg_waddr == REG_IRQ_STAT) ? i_reg_wdata[1:0] : 2'b00;
    assign rx_done = o_2711_enable & (i_rx_frame_ok | i_rx_frame_bad);

    assign o_tx_irq = irq_stat[0] & irq_mask[0];
    assign o_rx_irq = irq_stat[1] & irq_mask[1];

    //////////////////////////////////////////////////////////////
    // Configuration writes
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_2711_enable <= 1'b0;
            o_2711_loopen <= 1'b0;
            o_2711_pre    <= 1'b0;
            o_tx_go       <= 1'b0;
            o_tx_len      <= '0;
            irq_mask      <= 2'b00;
        end else begin
            o_tx_go <= 1'b0;
            if (i_reg_wen) begin
                case (i_reg_waddr)
                    REG_CTRL: begin
                        o_2711_enable <= i_reg_wdata[0];
                        o_2711_loopen <= i_reg_wdata[1];
                        o_2711_pre    <= i_reg_wdata[2];
                        // Go bit is never stored
                        o_tx_go       <= i_reg_wdata[3] & i_reg_wdata[0];
                    end
                    REG_TX_LEN:   o_tx_len <= i_reg_wdata[LEN_W-1:0];
                    REG_IRQ_MASK: irq_mask <= i_reg_wdata[1:0];
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////
    // Status, counters and interrupts
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_reset) begin
            sticky_csum <= 1'b0;
            sticky_ovf  <= 1'b0;
            rx_frames   <= '0;
            rx_errors   <= '0;
            irq_stat    <= 2'b00;
        end else begin
            if (i_rx_frame_bad)
                sticky_csum <= 1'b1;
            if (i_rx_overflow)
                sticky_ovf <= 1'b1;
            if (o_2711_enable && i_rx_frame_ok)
                rx_frames <= rx_frames + 1'b1;
            if (o_2711_enable && i_rx_frame_bad)
                rx_errors <= rx_errors + 1'b1;
            // New events win over a clear in the same cycle
            irq_stat <= (irq_stat & ~irq_clr) | {rx_done, i_tx_done};
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_reg_rdata <= '0;
        end else if (i_reg_ren) begin
            case (i_reg_raddr)
                REG_CTRL:      o_reg_rdata <= REG_DW'({o_2711_pre, o_2711_loopen, o_2711_enable});
                REG_TX_LEN:    o_reg_rdata <= REG_DW'(o_tx_len);
                REG_STATUS:    o_reg_rdata <= REG_DW'({sticky_ovf, sticky_csum,
                                                       i_rx_in_frame, i_tx_busy});
                REG_RX_FRAMES: o_reg_rdata <= rx_frames;
                REG_RX_ERRORS: o_reg_rdata <= rx_errors;
                REG_IRQ_STAT:  o_reg_rdata <= REG_DW'(irq_stat);
                REG_IRQ_MASK:  o_reg_rdata <= REG_DW'(irq_mask);
                default:       o_reg_rdata <= '0;
            endcase
        end
    end

endmodule

// ==== hw/tlk_link_top.sv ====
// TLK2711 link controller top
`timescale 1ns/1ps

module tlk_link_top
    import tlk_link_pkg::*;
(
    input  logic              clk,
    input  logic              i_reset,

    // Register bus
    input  logic              i_reg_wen,
    input  logic [REG_AW-1:0] i_reg_waddr,
    input  logic [REG_DW-1:0] i_reg_wdata,
    input  logic              i_reg_ren,
    input  logic [REG_AW-1:0] i_reg_raddr,
    output logic [REG_DW-1:0] o_reg_rdata,

    // Payload streams
    input  logic [WORD_W-1:0] i_tx_data,
    input  logic              i_tx_valid,
    output logic              o_tx_ready,
    output logic [WORD_W-1:0] o_rx_data,
    output logic              o_rx_valid,
    output logic              o_rx_last,
    output logic              o_rx_err,
    input  logic              i_rx_ready,

    output logic              o_tx_irq,
    output logic              o_rx_irq,

    // TLK2711 pins
    input  logic [WORD_W-1:0] i_2711_rxd,
    input  logic              i_2711_rkmsb,
    input  logic              i_2711_rklsb,
    output logic [WORD_W-1:0] o_2711_txd,
    output logic              o_2711_tkmsb,
    output logic              o_2711_tklsb,
    output logic              o_2711_enable,
    output logic              o_2711_loopen,
    output logic              o_2711_pre
);

    logic             tx_go;
    logic [LEN_W-1:0] tx_len;
    logic             tx_done;
    logic             tx_busy;
    logic             rx_frame_ok;
    logic             rx_frame_bad;
    logic             rx_overflow;
    logic             rx_in_frame;

    tlk_link_regs u_regs (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_reg_wen      (i_reg_wen),
        .i_reg_waddr    (i_reg_waddr),
        .i_reg_wdata    (i_reg_wdata),
        .i_reg_ren      (i_reg_ren),
        .i_reg_raddr    (i_reg_raddr),
        .o_reg_rdata    (o_reg_rdata),
        .i_tx_done      (tx_done),
        .i_tx_busy      (tx_busy),
        .i_rx_frame_ok  (rx_frame_ok),
        .i_rx_frame_bad (rx_frame_bad),
        .i_rx_overflow  (rx_overflow),
        .i_rx_in_frame  (rx_in_frame),
        .o_tx_go        (tx_go),
        .o_tx_len       (tx_len),
        .o_2711_enable  (o_2711_enable),
        .o_2711_loopen  (o_2711_loopen),
        .o_2711_pre     (o_2711_pre),
        .o_tx_irq       (o_tx_irq),
        .o_rx_irq       (o_rx_irq)
    );

    tlk_tx_framer u_tx (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_tx_go      (tx_go),
        .i_tx_len     (tx_len),
        .i_tx_data    (i_tx_data),
        .i_tx_valid   (i_tx_valid),
        .o_tx_ready   (o_tx_ready),
        .o_tx_done    (tx_done),
        .o_tx_busy    (tx_busy),
        .o_2711_txd   (o_2711_txd),
        .o_2711_tkmsb (o_2711_tkmsb),
        .o_2711_tklsb (o_2711_tklsb)
    );

    tlk_rx_deframer u_rx (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_2711_rxd     (i_2711_rxd),
        .i_2711_rkmsb   (i_2711_rkmsb),
        .i_2711_rklsb   (i_2711_rklsb),
        .o_rx_data      (o_rx_data),
        .o_rx_valid     (o_rx_valid),
        .o_rx_last      (o_rx_last),
        .o_rx_err       (o_rx_err),
        .i_rx_ready     (i_rx_ready),
        .o_rx_frame_ok  (rx_frame_ok),
        .o_rx_frame_bad (rx_frame_bad),
        .o_rx_overflow  (rx_overflow),
        .o_rx_in_frame  (rx_in_frame)
    );

endmodule

// ==== hw/tlk_rx_deframer.sv ====
// TLK2711 receive deframer
`timescale 1ns/1ps

module tlk_rx_deframer
    import tlk_link_pkg::*;
(
    input  logic              clk,
    input  logic              i_reset,

    input  logic [WORD_W-1:0] i_2711_rxd,
    input  logic              i_2711_rkmsb,
    input  logic              i_2711_rklsb,

    output logic [WORD_W-1:0] o_rx_data,
    output logic              o_rx_valid,
    output logic              o_rx_last,
    output logic              o_rx_err,
    input  logic              i_rx_ready,

    output logic              o_rx_frame_ok,
    output logic              o_rx_frame_bad,
    output logic              o_rx_overflow,
    output logic              o_rx_in_frame
);

    rx_state_e         state;
    logic [WORD_W-1:0] rxd_q;
    logic [1:0]        rk_q;
    logic [LEN_W-1:0]  remain;
    logic [WORD_W-1:0] csum;
    logic [WORD_W-1:0] last_q;
    logic              csum_ok;

    logic              any_k;
    logic              is_idle;
    logic              is_sof;
    logic              is_eof;
    logic              good;
    logic              push;
    logic              accept;
    logic [WORD_W-1:0] push_data;
    logic              push_last;

    assign any_k   = |rk_q;
    assign is_idle = (&rk_q) && (rxd_q == K_IDLE);
    assign is_sof  = (&rk_q) && (rxd_q == K_SOF);
    assign is_eof  = (&rk_q) && (rxd_q == K_EOF);
    assign good    = is_eof && csum_ok;

    assign o_rx_in_frame = (state != RX_HUNT);

    //////////////////////////////////////////////////////////////
    // Frame checks and stream push
    //////////////////////////////////////////////////////////////

    always_comb begin
        push           = 1'b0;
        push_data      = rxd_q;
        push_last      = 1'b0;
        o_rx_frame_ok  = 1'b0;
        o_rx_frame_bad = 1'b0;
        case (state)
            RX_LEN, RX_CSUM: o_rx_frame_bad = any_k;
            RX_BODY: begin
                o_rx_frame_bad = any_k && !is_idle;
                push           = !any_k && (remain != LEN_W'(1));
            end
            RX_EOF: begin
                // Held final word goes out with the verdict
                push           = 1'b1;
                push_data      = last_q;
                push_last      = 1'b1;
                o_rx_frame_ok  = good;
                o_rx_frame_bad = !good;
            end
            default: ;
        endcase
    end

    // Link cannot stall so a full output register drops the word
    assign accept        = push && !(o_rx_valid && !i_rx_ready);
    assign o_rx_overflow = push && o_rx_valid && !i_rx_ready;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state <= RX_HUNT;
            rk_q  <= 2'b00;
        end else begin
            rk_q <= {i_2711_rkmsb, i_2711_rklsb};
            case (state)
                RX_HUNT: if (is_sof) state <= RX_LEN;
                RX_LEN:  state <= any_k ? RX_HUNT : RX_BODY;
                RX_BODY: begin
                    if (any_k && !is_idle)
                        state <= RX_HUNT;
                    else if (!any_k && remain == LEN_W'(1))
                        state <= RX_CSUM;
                end
                RX_CSUM: state <= any_k ? RX_HUNT : RX_EOF;
                default: state <= RX_HUNT;
            endcase
        end
    end

    // Input stage, length count and checksum
    always_ff @(posedge clk) begin
        rxd_q <= i_2711_rxd;
        if (state == RX_LEN) begin
            remain <= rxd_q[LEN_W-1:0];
            csum   <= rxd_q;
        end else if (state == RX_BODY && !any_k) begin
            remain <= remain - 1'b1;
            csum   <= csum + rxd_q;
            if (remain == LEN_W'(1))
                last_q <= rxd_q;
        end
        if (state == RX_CSUM)
            csum_ok <= (rxd_q == csum);
    end

    //////////////////////////////////////////////////////////////
    // One word output register
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_reset)
            o_rx_valid <= 1'b0;
        else if (accept)
            o_rx_valid <= 1'b1;
        else if (i_rx_ready)
            o_rx_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_rx_data <= push_data;
            o_rx_last <= push_last;
            o_rx_err  <= push_last && !good;
        end
    end

endmodule

// ==== hw/tlk_tx_framer.sv ====
// TLK2711 transmit framer
`timescale 1ns/1ps

module tlk_tx_framer
    import tlk_link_pkg::*;
(
    input  logic              clk,
    input  logic              i_reset,

    input  logic              i_tx_go,
    input  logic [LEN_W-1:0]  i_tx_len,

    input  logic [WORD_W-1:0] i_tx_data,
    input  logic              i_tx_valid,
    output logic              o_tx_ready,

    output logic              o_tx_done,
    output logic              o_tx_busy,

    output logic [WORD_W-1:0] o_2711_txd,
    output logic              o_2711_tkmsb,
    output logic              o_2711_tklsb
);

    tx_state_e         state;
    logic [LEN_W-1:0]  remain;
    logic [WORD_W-1:0] csum;
    logic              take;
    logic [WORD_W-1:0] nxt_word;
    logic              nxt_k;

    assign o_tx_ready = (state == TX_BODY);
    assign o_tx_busy  = (state != TX_IDLE);
    assign take       = o_tx_ready & i_tx_valid;

    // Word loaded into the pin register at the next edge
    always_comb begin
        nxt_word = K_IDLE;
        nxt_k    = 1'b1;
        case (state)
            TX_IDLE: begin
                if (i_tx_go)
                    nxt_word = K_SOF;
            end
            TX_LEN: begin
                nxt_word = WORD_W'(remain);
                nxt_k    = 1'b0;
            end
            TX_BODY: begin
                if (take) begin
                    nxt_word = i_tx_data;
                    nxt_k    = 1'b0;
                end
            end
            TX_CSUM: begin
                nxt_word = csum;
                nxt_k    = 1'b0;
            end
            TX_EOF:  nxt_word = K_EOF;
            default: ;
        endcase
    end

    //////////////////////////////////////////////////////////////
    // Frame sequencer
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state        <= TX_IDLE;
            o_tx_done    <= 1'b0;
            o_2711_txd   <= K_IDLE;
            o_2711_tkmsb <= 1'b1;
            o_2711_tklsb <= 1'b1;
        end else begin
            // High while EOF sits on the pins
            o_tx_done    <= (state == TX_EOF);
            o_2711_txd   <= nxt_word;
            o_2711_tkmsb <= nxt_k;
            o_2711_tklsb <= nxt_k;
            case (state)
                TX_IDLE: if (i_tx_go) state <= TX_LEN;
                TX_LEN:  state <= TX_BODY;
                TX_BODY: if (take && remain == LEN_W'(1)) state <= TX_CSUM;
                TX_CSUM: state <= TX_EOF;
                TX_EOF:  state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

    // Length counter and running checksum
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && i_tx_go) begin
            remain <= i_tx_len;
            csum   <= WORD_W'(i_tx_len);
        end else if (take) begin
            remain <= remain - 1'b1;
            csum   <= csum + i_tx_data;
        end
    end

endmodule

// ==== testbench/tb_tlk_link_tasks.svh ====
// Link controller test tasks

//////////////////////////////////////////////////////////////
// Bus and stream helpers
//////////////////////////////////////////////////////////////

// Every step lands 2 ns after the rising edge
task automatic next_cycle();
    @(posedge clk);
    #2;
endtask

task automatic reg_write(input reg_addr_e addr, input logic [REG_DW-1:0] data);
    reg_wen   = 1'b1;
    reg_waddr = addr;
    reg_wdata = data;
    next_cycle();
    reg_wen   = 1'b0;
endtask

task automatic reg_read(input reg_addr_e addr, output logic [REG_DW-1:0] data);
    reg_ren   = 1'b1;
    reg_raddr = addr;
    next_cycle();
    reg_ren   = 1'b0;
    data      = reg_rdata;
endtask

task automatic check_word(input string name, input logic [WORD_W-1:0] expected,
                          input logic [WORD_W-1:0] actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("ERROR %s: expected 0x%04h, actual 0x%04h", name, expected, actual);
    end
endtask

task automatic check_reg(input string name, input logic [REG_DW-1:0] expected,
                         input logic [REG_DW-1:0] actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
    end
endtask

task automatic poll_reg(input reg_addr_e addr, input logic [REG_DW-1:0] expected,
                        input string name);
    logic [REG_DW-1:0] value;
    int                tries;
    tries = 0;
    reg_read(addr, value);
    while (value !== expected && tries < 16) begin
        reg_read(addr, value);
        tries++;
    end
    check_reg(name, expected, value);
endtask

task automatic wait_link_idle();
    logic [REG_DW-1:0] status;
    reg_read(REG_STATUS, status);
    while (status[0] || status[1])
        reg_read(REG_STATUS, status);
endtask

task automatic fill_frame(input int len);
    tx_words.delete();
    repeat (len) tx_words.push_back(WORD_W'($urandom()));
endtask

// Sum of the length word and body words modulo 2^16
function automatic logic [WORD_W-1:0] frame_csum();
    logic [WORD_W-1:0] sum;
    sum = WORD_W'(tx_words.size());
    foreach (tx_words[i])
        sum = sum + tx_words[i];
    return sum;
endfunction

task automatic start_frame(input logic loop);
    reg_write(REG_TX_LEN, REG_DW'(tx_words.size()));
    reg_write(REG_CTRL, {28'd0, 1'b1, 1'b0, loop, 1'b1});
endtask

task automatic send_stream(input logic gaps);
    int   idx;
    logic fire;
    idx = 0;
    while (idx < tx_words.size()) begin
        if (gaps && ($urandom() % 4 == 0)) begin
            tx_valid = 1'b0;
        end else begin
            tx_valid = 1'b1;
            tx_data  = tx_words[idx];
        end
        fire = tx_valid && tx_ready;
        next_cycle();
        if (fire)
            idx++;
    end
    tx_valid = 1'b0;
endtask

task automatic capture_tx_frame();
    logic started;
    logic done;
    logic is_k;
    cap_words.delete();
    cap_k.delete();
    started = 1'b0;
    done    = 1'b0;
    while (!done) begin
        next_cycle();
        is_k = tkmsb & tklsb;
        if (is_k && txd == K_SOF)
            started = 1'b1;
        if (started && !(is_k && txd == K_IDLE)) begin
            cap_words.push_back(txd);
            cap_k.push_back({tkmsb, tklsb});
            done = is_k && txd == K_EOF;
        end
    end
endtask

task automatic collect_rx_frame();
    logic done;
    rx_words.delete();
    rx_lasts.delete();
    rx_errs.delete();
    done = 1'b0;
    while (!done) begin
        next_cycle();
        if (rx_valid && rx_ready) begin
            rx_words.push_back(rx_data);
            rx_lasts.push_back(rx_last);
            rx_errs.push_back(rx_err);
            done = rx_last;
        end
    end
endtask

task automatic check_rx_frame(input string name, input logic exp_err);
    int last_idx;
    last_idx = rx_words.size() - 1;
    check_reg({name, " word count"}, REG_DW'(tx_words.size()), REG_DW'(rx_words.size()));
    foreach (rx_words[i]) begin
        if (i < tx_words.size())
            check_word($sformatf("%s data %0d", name, i), tx_words[i], rx_words[i]);
        check_word($sformatf("%s last %0d", name, i), WORD_W'(i == last_idx),
                   WORD_W'(rx_lasts[i]));
        check_word($sformatf("%s err %0d", name, i), WORD_W'(exp_err && i == last_idx),
                   WORD_W'(rx_errs[i]));
    end
endtask

//////////////////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////////////////

task automatic reset_regs_test();
    reg_addr_e         addr;
    logic [REG_DW-1:0] value;
    check_word("reset tx_ready", 16'd0, WORD_W'(tx_ready));
    check_word("reset rx_valid", 16'd0, WORD_W'(rx_valid));
    check_word("reset tx_irq", 16'd0, WORD_W'(tx_irq));
    check_word("reset rx_irq", 16'd0, WORD_W'(rx_irq));
    check_word("reset enable", 16'd0, WORD_W'(pin_enable));
    check_word("reset loopen", 16'd0, WORD_W'(pin_loopen));
    check_word("reset txd", K_IDLE, txd);
    addr = addr.first();
    do begin
        reg_read(addr, value);
        check_reg($sformatf("reset read %s", addr.name()), '0, value);
        addr = addr.next();
    end while (addr != addr.first());
    reg_write(REG_TX_LEN, 32'h0000_05A3);
    reg_read(REG_TX_LEN, value);
    check_reg("tx_len readback", 32'h0000_05A3, value);
    reg_write(REG_IRQ_MASK, 32'h0000_0003);
    reg_read(REG_IRQ_MASK, value);
    check_reg("irq_mask readback", 32'h0000_0003, value);
    // Pin controls without the go bit
    reg_write(REG_CTRL, 32'h0000_0007);
    check_word("ctrl enable pin", 16'd1, WORD_W'(pin_enable));
    check_word("ctrl loopen pin", 16'd1, WORD_W'(pin_loopen));
    check_word("ctrl pre pin", 16'd1, WORD_W'(pin_pre));
    reg_read(REG_CTRL, value);
    check_reg("ctrl readback", 32'h0000_0007, value);
    reg_write(REG_CTRL, 32'h0000_0000);
    check_word("ctrl pre cleared", 16'd0, WORD_W'(pin_pre));
endtask

task automatic tx_format_test();
    logic [WORD_W-1:0] expected[$];
    logic [1:0]        exp_k[$];
    fill_frame(5);
    expected.push_back(K_SOF);
    exp_k.push_back(2'b11);
    expected.push_back(WORD_W'(tx_words.size()));
    exp_k.push_back(2'b00);
    foreach (tx_words[i]) begin
        expected.push_back(tx_words[i]);
        exp_k.push_back(2'b00);
    end
    expected.push_back(frame_csum());
    exp_k.push_back(2'b00);
    expected.push_back(K_EOF);
    exp_k.push_back(2'b11);
    start_frame(1'b0);
    fork
        send_stream(1'b0);
        capture_tx_frame();
    join
    check_reg("tx format length", REG_DW'(expected.size()), REG_DW'(cap_words.size()));
    foreach (cap_words[i]) begin
        if (i < expected.size()) begin
            check_word($sformatf("tx format word %0d", i), expected[i], cap_words[i]);
            check_word($sformatf("tx format k %0d", i), WORD_W'(exp_k[i]),
                       WORD_W'(cap_k[i]));
        end
    end
    wait_link_idle();
endtask

task automatic loopback_test();
    int lens[3] = '{1, 8, 64};
    // Start from clear interrupt status so both outputs come from these frames
    reg_write(REG_IRQ_STAT, 32'h0000_0003);
    rx_ready = 1'b1;
    foreach (lens[i]) begin
        fill_frame(lens[i]);
        start_frame(1'b1);
        fork
            send_stream(1'b1);
            collect_rx_frame();
        join
        check_rx_frame($sformatf("loopback len %0d", lens[i]), 1'b0);
        wait_link_idle();
    end
    poll_reg(REG_RX_FRAMES, 32'd3, "rx frame count");
    check_word("loopback tx_irq", 16'd1, WORD_W'(tx_irq));
    check_word("loopback rx_irq", 16'd1, WORD_W'(rx_irq));
endtask

task automatic corrupt_test();
    logic [REG_DW-1:0] status;
    fill_frame(6);
    // Hit the checksum word after the length and body
    corrupt_idx = tx_words.size() + 1;
    corrupt_en  = 1'b1;
    start_frame(1'b1);
    fork
        send_stream(1'b0);
        collect_rx_frame();
    join
    corrupt_en = 1'b0;
    check_rx_frame("corrupt", 1'b1);
    wait_link_idle();
    poll_reg(REG_RX_ERRORS, 32'd1, "rx error count");
    reg_read(REG_STATUS, status);
    check_word("sticky checksum", 16'd1, WORD_W'(status[2]));
endtask

task automatic overflow_test();
    logic [REG_DW-1:0] status;
    int                shown;
    rx_ready = 1'b0;
    fill_frame(4);
    start_frame(1'b1);
    send_stream(1'b0);
    wait_link_idle();
    reg_read(REG_STATUS, status);
    check_word("sticky overflow", 16'd1, WORD_W'(status[3]));
    check_word("overflow valid held", 16'd1, WORD_W'(rx_valid));
    check_word("overflow held word", tx_words[0], rx_data);
    check_word("overflow held last", 16'd0, WORD_W'(rx_last));
    rx_ready = 1'b1;
    shown    = 0;
    repeat (8) begin
        next_cycle();
        if (rx_valid)
            shown++;
    end
    check_reg("overflow extra words", 32'd0, REG_DW'(shown));
endtask

task automatic irq_clear_test();
    logic [REG_DW-1:0] value;
    reg_write(REG_IRQ_STAT, 32'h0000_0003);
    check_word("cleared tx_irq", 16'd0, WORD_W'(tx_irq));
    check_word("cleared rx_irq", 16'd0, WORD_W'(rx_irq));
    reg_write(REG_IRQ_MASK, 32'h0000_0000);
    fill_frame(3);
    start_frame(1'b1);
    fork
        send_stream(1'b1);
        collect_rx_frame();
    join
    check_rx_frame("masked", 1'b0);
    wait_link_idle();
    check_word("masked tx_irq", 16'd0, WORD_W'(tx_irq));
    check_word("masked rx_irq", 16'd0, WORD_W'(rx_irq));
    reg_read(REG_IRQ_STAT, value);
    check_reg("masked irq status", 32'h0000_0003, value);
endtask

// ==== testbench/tb_tlk_link.sv ====
// TLK2711 link controller testbench
`timescale 1ns/1ps

module tb_tlk_link
    import tlk_link_pkg::*;
();

    localparam int CLK_HALF       = 20;
    localparam int RESET_CYCLES   = 16;
    localparam int RAND_SEED      = 77043;
    // Under 100 payload words in all so traffic and polling stay far below this
    localparam int TIMEOUT_CYCLES = 20000;

    logic              clk;
    logic              reset;

    logic              reg_wen;
    logic [REG_AW-1:0] reg_waddr;
    logic [REG_DW-1:0] reg_wdata;
    logic              reg_ren;
    logic [REG_AW-1:0] reg_raddr;
    logic [REG_DW-1:0] reg_rdata;

    logic [WORD_W-1:0] tx_data;
    logic              tx_valid;
    logic              tx_ready;
    logic [WORD_W-1:0] rx_data;
    logic              rx_valid;
    logic              rx_last;
    logic              rx_err;
    logic              rx_ready;
    logic              tx_irq;
    logic              rx_irq;

    logic [WORD_W-1:0] txd;
    logic              tkmsb;
    logic              tklsb;
    logic [WORD_W-1:0] rxd;
    logic              rkmsb;
    logic              rklsb;
    logic              pin_enable;
    logic              pin_loopen;
    logic              pin_pre;

    logic              corrupt_en;
    int                corrupt_idx;
    int                nonk_cnt;
    logic              corrupt_hit;

    // Frame data shared by the tasks
    logic [WORD_W-1:0] tx_words[$];
    logic [WORD_W-1:0] cap_words[$];
    logic [1:0]        cap_k[$];
    logic [WORD_W-1:0] rx_words[$];
    logic              rx_lasts[$];
    logic              rx_errs[$];

    int                check_count;
    int                error_count;
    int                cycle_count;

    `include "tb_tlk_link_tasks.svh"

    //////////////////////////////////////////////////////////////
    // Loopback path
    //////////////////////////////////////////////////////////////

    // Non-K words since the last SOF with the length word at index 0
    always @(posedge clk) begin
        if (reset)
            nonk_cnt <= 0;
        else if (tkmsb && tklsb && txd == K_SOF)
            nonk_cnt <= 0;
        else if (!tkmsb && !tklsb)
            nonk_cnt <= nonk_cnt + 1;
    end

    assign corrupt_hit = corrupt_en && !tkmsb && !tklsb && (nonk_cnt == corrupt_idx);
    assign rxd         = pin_loopen ? (txd ^ WORD_W'(corrupt_hit)) : K_IDLE;
    assign rkmsb       = pin_loopen ? tkmsb : 1'b1;
    assign rklsb       = pin_loopen ? tklsb : 1'b1;

    tlk_link_top u_dut (
        .clk           (clk),
        .i_reset       (reset),
        .i_reg_wen     (reg_wen),
        .i_reg_waddr   (reg_waddr),
        .i_reg_wdata   (reg_wdata),
        .i_reg_ren     (reg_ren),
        .i_reg_raddr   (reg_raddr),
        .o_reg_rdata   (reg_rdata),
        .i_tx_data     (tx_data),
        .i_tx_valid    (tx_valid),
        .o_tx_ready    (tx_ready),
        .o_rx_data     (rx_data),
        .o_rx_valid    (rx_valid),
        .o_rx_last     (rx_last),
        .o_rx_err      (rx_err),
        .i_rx_ready    (rx_ready),
        .o_tx_irq      (tx_irq),
        .o_rx_irq      (rx_irq),
        .i_2711_rxd    (rxd),
        .i_2711_rkmsb  (rkmsb),
        .i_2711_rklsb  (rklsb),
        .o_2711_txd    (txd),
        .o_2711_tkmsb  (tkmsb),
        .o_2711_tklsb  (tklsb),
        .o_2711_enable (pin_enable),
        .o_2711_loopen (pin_loopen),
        .o_2711_pre    (pin_pre)
    );

    //////////////////////////////////////////////////////////////
    // Clock, watchdog and test sequence
    //////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_count);
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(RAND_SEED));
        reset       = 1'b1;
        reg_wen     = 1'b0;
        reg_waddr   = '0;
        reg_wdata   = '0;
        reg_ren     = 1'b0;
        reg_raddr   = '0;
        tx_data     = '0;
        tx_valid    = 1'b0;
        rx_ready    = 1'b0;
        corrupt_en  = 1'b0;
        corrupt_idx = 0;
        check_count = 0;
        error_count = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;

        reset_regs_test();
        tx_format_test();
        loopback_test();
        corrupt_test();
        overflow_test();
        irq_clear_test();

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
